// ==== source/calc_pkg.sv ====
package calc_pkg;

  // Datapath widths
  localparam int DWORD_WIDTH    = 64;
  localparam int VADDR_WIDTH    = 39;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int SHAMT_WIDTH    = 6;

  // Stages tracked after the reservation register, EX1 to EX5
  localparam int PIPE_DEPTH     = 5;

  // Completion stage where each pipe drops its result
  localparam int INT_DONE_STAGE = 1;
  localparam int MUL_DONE_STAGE = 3;

  // Architectural points in the completion pipe
  localparam int COMMIT_STAGE   = 3;
  localparam int WB_STAGE       = 5;

  // Encoding is dense, MUL ops last
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_XOR  = 4'h4,
    OP_SLL  = 4'h5,
    OP_SRL  = 4'h6,
    OP_SLT  = 4'h7,
    OP_MUL  = 4'h8,
    OP_MULH = 4'h9
  } calc_op_e;

endpackage

// ==== source/calc_issue_if.sv ====
`timescale 1ns/100ps

interface calc_issue_if
  import calc_pkg::*;
(
  input logic clk_i
);

  // Reservation register contents, operands already bypassed
  calc_op_e                  op;
  logic [VADDR_WIDTH-1:0]    pc;
  logic [REG_ADDR_WIDTH-1:0] rd;
  logic [DWORD_WIDTH-1:0]    rs1;
  logic [DWORD_WIDTH-1:0]    rs2;

  modport issue (output op, pc, rd, rs1, rs2);
  modport ctrl  (input op, pc, rd);
  modport pipe  (input clk_i, op, rs1, rs2);

endinterface

// ==== source/calc_fwd_if.sv ====
`timescale 1ns/100ps

interface calc_fwd_if
  import calc_pkg::*;
();

  // Index k describes what stage k holds after the next edge
  logic [PIPE_DEPTH:1]                     fwd_v;
  logic [PIPE_DEPTH:1][REG_ADDR_WIDTH-1:0] fwd_rd;
  logic [PIPE_DEPTH:1][DWORD_WIDTH-1:0]    fwd_data;

  // Control side knows validity and destination
  modport ctrl (output fwd_v, fwd_rd);

  // Completion pipe knows the data
  modport comp (output fwd_data);

  // Operand bypass consumes everything
  modport bypass (input fwd_v, fwd_rd, fwd_data);

endinterface

// ==== source/calc_issue.sv ====
`timescale 1ns/100ps

module calc_issue
  import calc_pkg::*;
(
  input  logic                      clk_i,
  input  calc_op_e                  dispatch_op_i,
  input  logic [VADDR_WIDTH-1:0]    dispatch_pc_i,
  input  logic [REG_ADDR_WIDTH-1:0] dispatch_rd_i,
  input  logic [REG_ADDR_WIDTH-1:0] dispatch_rs1_addr_i,
  input  logic [REG_ADDR_WIDTH-1:0] dispatch_rs2_addr_i,
  input  logic [DWORD_WIDTH-1:0]    dispatch_rs1_i,
  input  logic [DWORD_WIDTH-1:0]    dispatch_rs2_i,
  calc_fwd_if.bypass                fwd_if,
  calc_issue_if.issue               issue_if
);

  logic [DWORD_WIDTH-1:0] bypass_rs1;
  logic [DWORD_WIDTH-1:0] bypass_rs2;

  // Youngest producer wins, so walk from oldest to youngest
  function automatic logic [DWORD_WIDTH-1:0] bypass_src(
    input logic [REG_ADDR_WIDTH-1:0]               addr,
    input logic [DWORD_WIDTH-1:0]                  rf_data,
    input logic [PIPE_DEPTH:1]                     fwd_v,
    input logic [PIPE_DEPTH:1][REG_ADDR_WIDTH-1:0] fwd_rd,
    input logic [PIPE_DEPTH:1][DWORD_WIDTH-1:0]    fwd_data
  );
    logic [DWORD_WIDTH-1:0] result;
    result = rf_data;
    for (int i = PIPE_DEPTH; i >= 1; i--)
    begin
      if (fwd_v[i] && (fwd_rd[i] == addr))
      begin
        result = fwd_data[i];
      end
    end
    // x0 is hardwired
    if (addr == '0)
    begin
      result = '0;
    end
    return result;
  endfunction

  assign bypass_rs1 = bypass_src(dispatch_rs1_addr_i, dispatch_rs1_i,
                                 fwd_if.fwd_v, fwd_if.fwd_rd, fwd_if.fwd_data);
  assign bypass_rs2 = bypass_src(dispatch_rs2_addr_i, dispatch_rs2_i,
                                 fwd_if.fwd_v, fwd_if.fwd_rd, fwd_if.fwd_data);

  // Reservation register
  always_ff @(posedge clk_i)
  begin
    issue_if.op  <= dispatch_op_i;
    issue_if.pc  <= dispatch_pc_i;
    issue_if.rd  <= dispatch_rd_i;
    issue_if.rs1 <= bypass_rs1;
    issue_if.rs2 <= bypass_rs2;
  end

endmodule

// ==== source/calc_pipe_int.sv ====
`timescale 1ns/100ps

module calc_pipe_int
  import calc_pkg::*;
(
  calc_issue_if.pipe             pipe_if,
  output logic [DWORD_WIDTH-1:0] data_o
);

  logic [SHAMT_WIDTH-1:0] shamt;
  logic                   rs1_lt_rs2;

  assign shamt      = pipe_if.rs2[SHAMT_WIDTH-1:0];
  assign rs1_lt_rs2 = $signed(pipe_if.rs1) < $signed(pipe_if.rs2);

  always_comb
  begin
    case (pipe_if.op)
      OP_ADD:  data_o = pipe_if.rs1 + pipe_if.rs2;
      OP_SUB:  data_o = pipe_if.rs1 - pipe_if.rs2;
      OP_AND:  data_o = pipe_if.rs1 & pipe_if.rs2;
      OP_OR:   data_o = pipe_if.rs1 | pipe_if.rs2;
      OP_XOR:  data_o = pipe_if.rs1 ^ pipe_if.rs2;
      OP_SLL:  data_o = pipe_if.rs1 << shamt;
      OP_SRL:  data_o = pipe_if.rs1 >> shamt;
      OP_SLT:  data_o = {{(DWORD_WIDTH-1){1'b0}}, rs1_lt_rs2};
      // Multiplies complete in their own pipe
      default: data_o = '0;
    endcase
  end

  // Reservation register is never loaded with an undefined opcode
  a_op_legal: assert property (
    @(posedge pipe_if.clk_i)
    !$isunknown(pipe_if.op) |-> (pipe_if.op inside {[OP_ADD:OP_MULH]})
  )
  else $error("reservation holds illegal opcode %0h", pipe_if.op);

endmodule

// ==== source/calc_pipe_mul.sv ====
`timescale 1ns/100ps

module calc_pipe_mul
  import calc_pkg::*;
(
  input  logic                   clk_i,
  calc_issue_if.pipe             pipe_if,
  output logic [DWORD_WIDTH-1:0] data_o
);

  calc_op_e                          op_ex1;
  calc_op_e                          op_ex2;
  logic [DWORD_WIDTH-1:0]            rs1_ex1;
  logic [DWORD_WIDTH-1:0]            rs2_ex1;
  logic signed [2*DWORD_WIDTH-1:0]   prod_ex2;

  // EX1 captures operands
  always_ff @(posedge clk_i)
  begin
    op_ex1  <= pipe_if.op;
    rs1_ex1 <= pipe_if.rs1;
    rs2_ex1 <= pipe_if.rs2;
  end

  // EX2 captures the full signed product
  always_ff @(posedge clk_i)
  begin
    op_ex2   <= op_ex1;
    prod_ex2 <= $signed(rs1_ex1) * $signed(rs2_ex1);
  end

  // Low half is the same for signed and unsigned
  assign data_o = (op_ex2 == OP_MULH) ? prod_ex2[2*DWORD_WIDTH-1:DWORD_WIDTH]
                                      : prod_ex2[DWORD_WIDTH-1:0];

endmodule

// ==== source/calc_comp_pipe.sv ====
`timescale 1ns/100ps

module calc_comp_pipe
  import calc_pkg::*;
(
  input  logic                   clk_i,
  input  logic [DWORD_WIDTH-1:0] int_data_i,
  input  logic [DWORD_WIDTH-1:0] mul_data_i,
  input  logic                   int_sel_i,
  input  logic                   mul_sel_i,
  calc_fwd_if.comp               fwd_if,
  output logic [DWORD_WIDTH-1:0] wb_data_o
);

  logic [PIPE_DEPTH:1][DWORD_WIDTH-1:0] comp_n;
  logic [PIPE_DEPTH:1][DWORD_WIDTH-1:0] comp_r;

  // Shift down, then let a finishing pipe overwrite its stage
  always_comb
  begin
    comp_n[1] = '0;
    for (int i = 2; i <= PIPE_DEPTH; i++)
    begin
      comp_n[i] = comp_r[i-1];
    end
    if (int_sel_i)
    begin
      comp_n[INT_DONE_STAGE] = int_data_i;
    end
    if (mul_sel_i)
    begin
      comp_n[MUL_DONE_STAGE] = mul_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    comp_r <= comp_n;
  end

  // Next-state data so a result is visible the cycle it lands
  assign fwd_if.fwd_data = comp_n;
  assign wb_data_o       = comp_r[WB_STAGE];

  // A multiply result belongs to an instruction that skipped the integer
  // stage when it sat in the reservation slot
  a_sel_exclusive: assert property (
    @(posedge clk_i)
    mul_sel_i |-> !$past(int_sel_i, MUL_DONE_STAGE - 1)
  )
  else $error("integer and multiply results selected for one instruction");

endmodule

// ==== source/calc_ctrl.sv ====
`timescale 1ns/100ps

module calc_ctrl
  import calc_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      dispatch_v_i,
  input  logic                      flush_i,
  calc_issue_if.ctrl                issue_if,
  calc_fwd_if.ctrl                  fwd_if,
  output logic                      int_sel_o,
  output logic                      mul_sel_o,
  output logic                      commit_v_o,
  output logic [VADDR_WIDTH-1:0]    commit_pc_o,
  output logic                      wb_v_o,
  output logic [REG_ADDR_WIDTH-1:0] wb_rd_o
);

  // Index 0 is the reservation slot
  logic [PIPE_DEPTH:0]                     v_r;
  logic [PIPE_DEPTH:0]                     poison_r;
  logic [PIPE_DEPTH:0]                     poison_n;
  logic [PIPE_DEPTH:0][REG_ADDR_WIDTH-1:0] rd_cur;

  // Payload carried only as far as it is needed
  logic [PIPE_DEPTH:1][REG_ADDR_WIDTH-1:0] rd_r;
  logic [COMMIT_STAGE:1][VADDR_WIDTH-1:0]  pc_r;
  logic [MUL_DONE_STAGE-1:1]               mul_r;
  logic                                    res_mul;

  assign res_mul = issue_if.op inside {OP_MUL, OP_MULH};
  assign rd_cur  = {rd_r, issue_if.rd};

  // Flush kills everything short of the commit point
  always_comb
  begin
    poison_n[0] = flush_i;
    for (int i = 1; i <= PIPE_DEPTH; i++)
    begin
      if (i < COMMIT_STAGE)
      begin
        poison_n[i] = poison_r[i-1] | flush_i;
      end
      else
      begin
        poison_n[i] = poison_r[i-1];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      v_r      <= '0;
      poison_r <= '0;
    end
    else
    begin
      v_r      <= {v_r[PIPE_DEPTH-1:0], dispatch_v_i};
      poison_r <= poison_n;
    end
  end

  always_ff @(posedge clk_i)
  begin
    rd_r  <= {rd_r[PIPE_DEPTH-1:1], issue_if.rd};
    pc_r  <= {pc_r[COMMIT_STAGE-1:1], issue_if.pc};
    mul_r <= {mul_r[MUL_DONE_STAGE-2:1], res_mul};
  end

  // Result routing into the completion pipe
  assign int_sel_o = v_r[INT_DONE_STAGE-1] & ~res_mul;
  assign mul_sel_o = v_r[MUL_DONE_STAGE-1] & mul_r[MUL_DONE_STAGE-1];

  // Stage k after the edge is what sits in stage k-1 now
  always_comb
  begin
    for (int i = 1; i <= PIPE_DEPTH; i++)
    begin
      fwd_if.fwd_v[i] = v_r[i-1] & ~poison_n[i] & (rd_cur[i-1] != '0);
    end
  end

  assign fwd_if.fwd_rd = rd_cur[PIPE_DEPTH-1:0];

  assign commit_v_o  = v_r[COMMIT_STAGE] & ~poison_r[COMMIT_STAGE];
  assign commit_pc_o = pc_r[COMMIT_STAGE];

  // x0 destinations commit but never write back
  assign wb_v_o  = v_r[WB_STAGE] & ~poison_r[WB_STAGE] & (rd_r[WB_STAGE] != '0);
  assign wb_rd_o = rd_r[WB_STAGE];

  // Destination traced back to the reservation slot it left
  a_wb_rd_nonzero: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    wb_v_o |-> ($past(issue_if.rd, WB_STAGE) != '0)
  )
  else $error("write-back to x0");

endmodule

// ==== source/calc_top.sv ====
`timescale 1ns/100ps

module calc_top
  import calc_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      dispatch_v_i,
  input  calc_op_e                  dispatch_op_i,
  input  logic [VADDR_WIDTH-1:0]    dispatch_pc_i,
  input  logic [REG_ADDR_WIDTH-1:0] dispatch_rd_i,
  input  logic [REG_ADDR_WIDTH-1:0] dispatch_rs1_addr_i,
  input  logic [REG_ADDR_WIDTH-1:0] dispatch_rs2_addr_i,
  input  logic [DWORD_WIDTH-1:0]    dispatch_rs1_i,
  input  logic [DWORD_WIDTH-1:0]    dispatch_rs2_i,
  input  logic                      flush_i,
  output logic                      commit_v_o,
  output logic [VADDR_WIDTH-1:0]    commit_pc_o,
  output logic                      wb_v_o,
  output logic [REG_ADDR_WIDTH-1:0] wb_rd_o,
  output logic [DWORD_WIDTH-1:0]    wb_data_o
);

  logic [DWORD_WIDTH-1:0] int_data;
  logic [DWORD_WIDTH-1:0] mul_data;
  logic                   int_sel;
  logic                   mul_sel;

  calc_issue_if issue_if (.clk_i(clk_i));
  calc_fwd_if   fwd_if ();

  // Bypass and reservation register
  calc_issue i_issue (
    .clk_i               (clk_i),
    .dispatch_op_i       (dispatch_op_i),
    .dispatch_pc_i       (dispatch_pc_i),
    .dispatch_rd_i       (dispatch_rd_i),
    .dispatch_rs1_addr_i (dispatch_rs1_addr_i),
    .dispatch_rs2_addr_i (dispatch_rs2_addr_i),
    .dispatch_rs1_i      (dispatch_rs1_i),
    .dispatch_rs2_i      (dispatch_rs2_i),
    .fwd_if              (fwd_if.bypass),
    .issue_if            (issue_if.issue)
  );

  // Execution pipes
  calc_pipe_int i_pipe_int (
    .pipe_if (issue_if.pipe),
    .data_o  (int_data)
  );

  calc_pipe_mul i_pipe_mul (
    .clk_i   (clk_i),
    .pipe_if (issue_if.pipe),
    .data_o  (mul_data)
  );

  calc_comp_pipe i_comp_pipe (
    .clk_i      (clk_i),
    .int_data_i (int_data),
    .mul_data_i (mul_data),
    .int_sel_i  (int_sel),
    .mul_sel_i  (mul_sel),
    .fwd_if     (fwd_if.comp),
    .wb_data_o  (wb_data_o)
  );

  calc_ctrl i_ctrl (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .dispatch_v_i (dispatch_v_i),
    .flush_i      (flush_i),
    .issue_if     (issue_if.ctrl),
    .fwd_if       (fwd_if.ctrl),
    .int_sel_o    (int_sel),
    .mul_sel_o    (mul_sel),
    .commit_v_o   (commit_v_o),
    .commit_pc_o  (commit_pc_o),
    .wb_v_o       (wb_v_o),
    .wb_rd_o      (wb_rd_o)
  );

endmodule

// ==== bench/tb_calc.sv ====
`timescale 1ns/100ps

module tb_calc
  import calc_pkg::*;
();

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_CYCLES   = 512;
  localparam int NUM_FIELDS   = 14;

  logic                      clk;
  logic                      arst_n;
  logic                      dispatch_v;
  calc_op_e                  dispatch_op;
  logic [VADDR_WIDTH-1:0]    dispatch_pc;
  logic [REG_ADDR_WIDTH-1:0] dispatch_rd;
  logic [REG_ADDR_WIDTH-1:0] dispatch_rs1_addr;
  logic [REG_ADDR_WIDTH-1:0] dispatch_rs2_addr;
  logic [DWORD_WIDTH-1:0]    dispatch_rs1;
  logic [DWORD_WIDTH-1:0]    dispatch_rs2;
  logic                      flush;
  logic                      commit_v;
  logic [VADDR_WIDTH-1:0]    commit_pc;
  logic                      wb_v;
  logic [REG_ADDR_WIDTH-1:0] wb_rd;
  logic [DWORD_WIDTH-1:0]    wb_data;

  // One row per cycle, columns in trace file order
  logic [63:0] trace_mem [0:MAX_CYCLES-1][0:NUM_FIELDS-1];
  int          num_cycles;
  int          test_start[$];
  string       test_name[$];
  int          error_count;
  int          tests_failed;
  bit          trace_ready;

  calc_top i_calc_top (
    .clk_i               (clk),
    .arst_n_i            (arst_n),
    .dispatch_v_i        (dispatch_v),
    .dispatch_op_i       (dispatch_op),
    .dispatch_pc_i       (dispatch_pc),
    .dispatch_rd_i       (dispatch_rd),
    .dispatch_rs1_addr_i (dispatch_rs1_addr),
    .dispatch_rs2_addr_i (dispatch_rs2_addr),
    .dispatch_rs1_i      (dispatch_rs1),
    .dispatch_rs2_i      (dispatch_rs2),
    .flush_i             (flush),
    .commit_v_o          (commit_v),
    .commit_pc_o         (commit_pc),
    .wb_v_o              (wb_v),
    .wb_rd_o             (wb_rd),
    .wb_data_o           (wb_data)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  task automatic report_error(input string msg);
    $display("error %0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic load_trace(output bit ok);
    int          fd;
    int          code;
    int          ch;
    string       tag;
    string       name;
    logic [63:0] f [0:NUM_FIELDS-1];
    ok = 1'b0;
    num_cycles = 0;
    fd = $fopen("bench/calc_trace.txt", "r");
    if (fd == 0)
    begin
      $display("trace file bench/calc_trace.txt could not be opened");
      return;
    end
    ok = 1'b1;
    while ($fscanf(fd, "%s", tag) == 1)
    begin
      if (tag == "#")
      begin
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1)
          ch = $fgetc(fd);
      end
      else if (tag == "T")
      begin
        code = $fscanf(fd, "%s", name);
        test_name.push_back(name);
        test_start.push_back(num_cycles);
      end
      else if (tag == "C" && num_cycles < MAX_CYCLES)
      begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                       f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
        if (code != NUM_FIELDS)
        begin
          $display("trace line %0d has %0d fields instead of %0d", num_cycles, code, NUM_FIELDS);
          ok = 1'b0;
        end
        for (int i = 0; i < NUM_FIELDS; i++)
          trace_mem[num_cycles][i] = f[i];
        num_cycles++;
      end
      else
      begin
        $display("trace file holds an entry that cannot be read: %s", tag);
        ok = 1'b0;
      end
    end
    $fclose(fd);
    if (test_name.size() == 0)
    begin
      $display("trace file holds no test");
      ok = 1'b0;
    end
  endtask

  // Sampled by the DUT at the following edge
  task automatic drive_cycle(input int k);
    dispatch_v        <= trace_mem[k][0][0];
    dispatch_op       <= calc_op_e'(trace_mem[k][1][3:0]);
    dispatch_pc       <= trace_mem[k][2][VADDR_WIDTH-1:0];
    dispatch_rd       <= trace_mem[k][3][REG_ADDR_WIDTH-1:0];
    dispatch_rs1_addr <= trace_mem[k][4][REG_ADDR_WIDTH-1:0];
    dispatch_rs2_addr <= trace_mem[k][5][REG_ADDR_WIDTH-1:0];
    dispatch_rs1      <= trace_mem[k][6];
    dispatch_rs2      <= trace_mem[k][7];
    flush             <= trace_mem[k][8][0];
  endtask

  task automatic check_cycle(input int k);
    logic                      exp_commit_v;
    logic [VADDR_WIDTH-1:0]    exp_commit_pc;
    logic                      exp_wb_v;
    logic [REG_ADDR_WIDTH-1:0] exp_wb_rd;
    logic [DWORD_WIDTH-1:0]    exp_wb_data;
    exp_commit_v  = trace_mem[k][9][0];
    exp_commit_pc = trace_mem[k][10][VADDR_WIDTH-1:0];
    exp_wb_v      = trace_mem[k][11][0];
    exp_wb_rd     = trace_mem[k][12][REG_ADDR_WIDTH-1:0];
    exp_wb_data   = trace_mem[k][13];
    if (commit_v !== exp_commit_v)
      report_error($sformatf("cycle %0d commit_v is %b, expected %b", k, commit_v, exp_commit_v));
    else if (exp_commit_v && commit_pc !== exp_commit_pc)
      report_error($sformatf("cycle %0d commit_pc is %h, expected %h", k, commit_pc, exp_commit_pc));
    if (wb_v !== exp_wb_v)
      report_error($sformatf("cycle %0d wb_v is %b, expected %b", k, wb_v, exp_wb_v));
    else if (exp_wb_v && wb_rd !== exp_wb_rd)
      report_error($sformatf("cycle %0d wb_rd is %h, expected %h", k, wb_rd, exp_wb_rd));
    if (exp_wb_v && wb_data !== exp_wb_data)
      report_error($sformatf("cycle %0d wb_data is %h, expected %h", k, wb_data, exp_wb_data));
  endtask

  task automatic run_test(input int t);
    int first;
    int last;
    int errors_before;
    first = test_start[t];
    last = (t + 1 < test_start.size()) ? test_start[t+1] : num_cycles;
    errors_before = error_count;
    for (int k = first; k < last; k++)
    begin
      @(posedge clk);
      drive_cycle(k);
      // Outputs settle well before the falling edge
      @(negedge clk);
      check_cycle(k);
    end
    if (error_count != errors_before)
      tests_failed++;
    $display("test %s: %0d cycles, %0d errors", test_name[t], last - first,
             error_count - errors_before);
  endtask

  initial
  begin
    bit trace_ok;
    clk               = 1'b0;
    arst_n            = 1'b0;
    dispatch_v        = 1'b0;
    dispatch_op       = OP_ADD;
    dispatch_pc       = '0;
    dispatch_rd       = '0;
    dispatch_rs1_addr = '0;
    dispatch_rs2_addr = '0;
    dispatch_rs1      = '0;
    dispatch_rs2      = '0;
    flush             = 1'b0;
    error_count       = 0;
    tests_failed      = 0;
    trace_ready       = 1'b0;
    load_trace(trace_ok);
    if (trace_ok)
    begin
      trace_ready = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
      for (int t = 0; t < test_name.size(); t++)
        run_test(t);
      $display("tests run %0d, tests failed %0d, errors %0d",
               test_name.size(), tests_failed, error_count);
    end
    if (trace_ok && error_count == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Twice the trace length plus reset
  initial
  begin
    int timeout_ns;
    wait (trace_ready);
    timeout_ns = (num_cycles * 2 + RESET_CYCLES) * CLK_PERIOD;
    #(timeout_ns);
    $display("watchdog expired, the run did not finish within %0d ns", timeout_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== list.f ====
source/calc_pkg.sv
source/calc_issue_if.sv
source/calc_fwd_if.sv
source/calc_issue.sv
source/calc_pipe_int.sv
source/calc_pipe_mul.sv
source/calc_comp_pipe.sv
source/calc_ctrl.sv
source/calc_top.sv
bench/tb_calc.sv

// ==== bench/calc_trace.txt ====
# T name starts a test; C v op pc rd rs1_addr rs2_addr rs1 rs2 flush, then expected
# commit_v commit_pc wb_v wb_rd wb_data, all hex; commit 4 and write-back 6 lines after dispatch
T reset_idle
C 0 0 0 0 0 0 0 0 0  0 0 0 0 0
C 0 0 0 0 0 0 0 0 0  0 0 0 0 0
C 0 0 0 0 0 0 0 0 0  0 0 0 0 0
T alu_ops
C 1 0 100 10 1 2 7fffffffffffffff 1 0  0 0 0 0 0
C 1 1 104 11 1 2 5 7 0  0 0 0 0 0
C 1 2 108 12 1 2 ff00ff00 ff00ff0 0  0 0 0 0 0
C 1 3 10c 13 1 2 ff00ff00 ff00ff0 0  0 0 0 0 0
C 1 4 110 14 1 2 ff00ff00 ff00ff0 0  1 100 0 0 0
C 1 5 114 15 1 2 1 43 0  1 104 0 0 0
C 1 6 118 16 1 2 8000000000000000 3f 0  1 108 1 10 8000000000000000
C 1 7 11c 17 1 2 ffffffffffffffff 1 0  1 10c 1 11 fffffffffffffffe
C 0 0 0 0 0 0 0 0 0  1 110 1 12 f000f00
C 0 0 0 0 0 0 0 0 0  1 114 1 13 fff0fff0
C 0 0 0 0 0 0 0 0 0  1 118 1 14 f0f0f0f0
C 0 0 0 0 0 0 0 0 0  1 11c 1 15 8
C 0 0 0 0 0 0 0 0 0  0 0 1 16 1
C 0 0 0 0 0 0 0 0 0  0 0 1 17 1
T forwarding
C 1 0 200 5 1 2 3 4 0  0 0 0 0 0
C 1 0 204 6 5 5 dead dead 0  0 0 0 0 0
C 1 4 208 5 6 5 dead dead 0  0 0 0 0 0
C 1 8 20c 7 5 6 dead dead 0  0 0 0 0 0
C 0 0 0 0 0 0 0 0 0  1 200 0 0 0
C 0 0 0 0 0 0 0 0 0  1 204 0 0 0
C 1 9 210 8 7 3 dead 8000000000000000 0  1 208 1 5 7
C 0 0 0 0 0 0 0 0 0  1 20c 1 6 e
C 0 0 0 0 0 0 0 0 0  0 0 1 5 9
C 1 0 214 9 8 8 dead dead 0  0 0 1 7 7e
C 0 0 0 0 0 0 0 0 0  1 210 0 0 0
C 0 0 0 0 0 0 0 0 0  0 0 0 0 0
C 0 0 0 0 0 0 0 0 0  0 0 1 8 ffffffffffffffc1
C 0 0 0 0 0 0 0 0 0  1 214 0 0 0
C 0 0 0 0 0 0 0 0 0  0 0 0 0 0
C 0 0 0 0 0 0 0 0 0  0 0 1 9 ffffffffffffff82
T flush
C 1 0 300 a 1 2 10 20 0  0 0 0 0 0
C 1 1 304 b 1 2 100 1 0  0 0 0 0 0
C 1 3 308 c 1 2 f0 f 0  0 0 0 0 0
C 1 0 30c d 1 2 1 2 0  0 0 0 0 0
C 1 8 310 e 1 2 3 4 1  1 300 0 0 0
C 1 0 314 f e d 1000 234 0  1 304 0 0 0
C 1 0 318 10 b a dead 30 0  0 0 1 a 30
C 0 0 0 0 0 0 0 0 0  0 0 1 b ff
C 0 0 0 0 0 0 0 0 0  0 0 0 0 0
C 0 0 0 0 0 0 0 0 0  1 314 0 0 0
C 0 0 0 0 0 0 0 0 0  1 318 0 0 0
C 0 0 0 0 0 0 0 0 0  0 0 1 f 1234
C 0 0 0 0 0 0 0 0 0  0 0 1 10 12f
T reg_zero
C 1 0 400 3 0 0 5555 aaaa 0  0 0 0 0 0
C 1 0 404 0 1 2 7 8 0  0 0 0 0 0
C 1 0 408 4 0 2 77 8 0  0 0 0 0 0
C 0 0 0 0 0 0 0 0 0  0 0 0 0 0
C 0 0 0 0 0 0 0 0 0  1 400 0 0 0
C 0 0 0 0 0 0 0 0 0  1 404 0 0 0
C 0 0 0 0 0 0 0 0 0  1 408 1 3 0
C 0 0 0 0 0 0 0 0 0  0 0 0 0 0
C 0 0 0 0 0 0 0 0 0  0 0 1 4 8
